// ==== io_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared widths, register offsets and bus response codes for the
// peripheral block; referenced by scoped name from each module
//////////////////////////////////////////////////////////////////////
package io_pkg;

	// bus side
	typedef logic [7:0]  addr_t;     // register byte address
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;

	// peripheral side
	typedef logic [3:0]  sdc_t;      // one bit per sd data lane
	typedef logic [7:0]  ps2_byte_t;
	typedef logic [7:0]  duty_t;     // pwm high count per 256 cycles

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// register map, word aligned
	localparam addr_t REG_SDC_DIR  = 8'h00;  // lane drive enables
	localparam addr_t REG_SDC_OUT  = 8'h04;  // lanes, clk, cmd, ena
	localparam addr_t REG_SDC_IN   = 8'h08;  // synchronized pads, read only
	localparam addr_t REG_PS2_CTRL = 8'h0C;  // inhibit plus status flags
	localparam addr_t REG_PS2_DATA = 8'h10;  // read clears the flags
	localparam addr_t REG_AUD_DUTY = 8'h14;

	// bit positions in REG_SDC_OUT above the lanes
	localparam int SDC_CLK_BIT = 4;
	localparam int SDC_CMD_BIT = 5;
	localparam int SDC_ENA_BIT = 6;

endpackage

// ==== ps2_rx.sv ====
//////////////////////////////////////////////////////////////////////
// receive side of a ps/2 port: takes device frames off the synchronized
// pins and holds the last byte with valid, parity and overrun flags
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ps2_rx (
	input  logic              clock,
	input  logic              reset_i,
	input  logic              ps2_clk_i,
	input  logic              ps2_data_i,
	input  logic              inhibit_i,     // host holds the clock low
	input  logic              take_i,        // byte consumed, clear flags
	output io_pkg::ps2_byte_t byte_o,
	output logic              valid_o,
	output logic              parity_err_o,
	output logic              overrun_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DATA,
		ST_PARITY,
		ST_STOP
	} state_t;

	state_t            state;
	logic [1:0]        clk_sync;
	logic [1:0]        data_sync;
	logic              clk_prev;
	logic              clk_fall;
	logic              bit_in;
	logic [2:0]        bit_cnt;
	io_pkg::ps2_byte_t shift_q;
	logic              parity_q;
	logic              frame_done;
	logic              bad_parity;

	// pins idle high, so the sync chain resets high to avoid a false fall
	always_ff @(posedge clock) begin
		if (reset_i) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk_i};
			data_sync <= {data_sync[0], ps2_data_i};
			clk_prev  <= clk_sync[1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[1];
	assign bit_in   = data_sync[1];

	// stop bit has to be 1, otherwise the frame is thrown away
	assign frame_done = (state == ST_STOP) && clk_fall && bit_in && !inhibit_i;
	assign bad_parity = ~^{shift_q, parity_q};  // odd parity over data + parity

	always_ff @(posedge clock) begin
		if (reset_i) begin
			state   <= ST_IDLE;
			bit_cnt <= '0;
		end else if (inhibit_i) begin
			state   <= ST_IDLE;  // frame restarts after release
			bit_cnt <= '0;
		end else if (clk_fall) begin
			case (state)
				ST_IDLE: begin
					if (!bit_in) begin  // start bit
						state   <= ST_DATA;
						bit_cnt <= '0;
					end
				end
				ST_DATA: begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
						state <= ST_PARITY;
				end
				ST_PARITY: state <= ST_STOP;
				default:   state <= ST_IDLE;  // stop bit, good or bad
			endcase
		end
	end

	// data arrives lsb first
	always_ff @(posedge clock) begin
		if (clk_fall && state == ST_DATA)
			shift_q <= {bit_in, shift_q[7:1]};
		if (clk_fall && state == ST_PARITY)
			parity_q <= bit_in;
	end

	always_ff @(posedge clock) begin
		if (reset_i) begin
			byte_o       <= '0;
			valid_o      <= 1'b0;
			parity_err_o <= 1'b0;
			overrun_o    <= 1'b0;
		end else if (frame_done) begin
			byte_o       <= shift_q;
			valid_o      <= 1'b1;
			parity_err_o <= bad_parity | (parity_err_o & ~take_i);
			overrun_o    <= (overrun_o | valid_o) & ~take_i;  // old byte never read
		end else if (take_i) begin
			valid_o      <= 1'b0;
			parity_err_o <= 1'b0;
			overrun_o    <= 1'b0;
		end
	end

endmodule

// ==== audio_pwm.sv ====
//////////////////////////////////////////////////////////////////////
// 8-bit pwm for the mono audio pad, period of 256 clocks
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module audio_pwm (
	input  logic          clock,
	input  logic          reset_i,
	input  io_pkg::duty_t duty_i,
	output logic          pwm_o
);

	io_pkg::duty_t cnt_q;
	io_pkg::duty_t duty_q;
	logic          wrap;

	// last count of the period
	assign wrap = (cnt_q == 8'hFF);

	always_ff @(posedge clock) begin
		if (reset_i) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= cnt_q + 8'd1;  // free running, wraps by itself
		end
	end

	// new duty only at the period boundary so no period comes out
	// with a partial high time
	always_ff @(posedge clock) begin
		if (reset_i) begin
			duty_q <= '0;
		end else if (wrap) begin
			duty_q <= duty_i;
		end
	end

	// high for the first duty_q counts, duty 0 stays low
	assign pwm_o = (cnt_q < duty_q);

endmodule

// ==== core_unit.sv ====
//////////////////////////////////////////////////////////////////////
// axi4-lite register block for the sd, ps/2 and audio pads; the pad
// wrapper feeds it split in/out/enable signals
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module core_unit (
	input  logic          clock,
	input  logic          reset_i,

	input  io_pkg::addr_t s_awaddr_i,
	input  logic          s_awvalid_i,
	output logic          s_awready_o,
	input  io_pkg::data_t s_wdata_i,
	input  io_pkg::strb_t s_wstrb_i,
	input  logic          s_wvalid_i,
	output logic          s_wready_o,
	output io_pkg::resp_t s_bresp_o,
	output logic          s_bvalid_o,
	input  logic          s_bready_i,
	input  io_pkg::addr_t s_araddr_i,
	input  logic          s_arvalid_i,
	output logic          s_arready_o,
	output io_pkg::data_t s_rdata_o,
	output io_pkg::resp_t s_rresp_o,
	output logic          s_rvalid_o,
	input  logic          s_rready_i,

	input  io_pkg::sdc_t  sdc_dat_in_i,
	output io_pkg::sdc_t  sdc_dat_o,
	output io_pkg::sdc_t  sdc_dat_drive_o,
	output logic          sdc_clk_o,
	output logic          sdc_cmd_o,
	output logic          sdc_ena_o,

	input  logic          ps2_clk_in_i,
	input  logic          ps2_data_in_i,
	output logic          ps2_clk_drive_o,

	output logic          aud_pwm_o
);

	typedef enum logic [1:0] {
		AX_IDLE,
		AX_ACK,    // ready high this cycle, transfer on the edge
		AX_RESP    // response waiting for the master
	} ax_state_t;

	ax_state_t         wr_state;
	ax_state_t         rd_state;
	logic              wr_fire;
	logic              rd_fire;
	logic              wr_mapped;
	logic              wr_lane0;
	io_pkg::data_t     rd_data;
	io_pkg::resp_t     rd_resp;

	io_pkg::sdc_t      sdc_in_q1;
	io_pkg::sdc_t      sdc_in_q2;
	logic              ps2_inhibit;
	logic              ps2_take;
	io_pkg::ps2_byte_t ps2_byte;
	logic              ps2_valid;
	logic              ps2_parity_err;
	logic              ps2_overrun;
	io_pkg::duty_t     aud_duty;

	assign wr_fire  = (wr_state == AX_ACK);
	assign rd_fire  = (rd_state == AX_ACK) && s_arvalid_i;
	assign wr_lane0 = wr_fire && s_wstrb_i[0];

	assign s_awready_o = (wr_state == AX_ACK);
	assign s_wready_o  = (wr_state == AX_ACK);
	assign s_bvalid_o  = (wr_state == AX_RESP);
	assign s_arready_o = (rd_state == AX_ACK);
	assign s_rvalid_o  = (rd_state == AX_RESP);

	always_comb begin
		case (s_awaddr_i)
			io_pkg::REG_SDC_DIR, io_pkg::REG_SDC_OUT, io_pkg::REG_SDC_IN,
			io_pkg::REG_PS2_CTRL, io_pkg::REG_PS2_DATA,
			io_pkg::REG_AUD_DUTY: wr_mapped = 1'b1;
			default:              wr_mapped = 1'b0;
		endcase
	end

	// one write in flight: idle, accept, respond
	always_ff @(posedge clock) begin
		if (reset_i) begin
			wr_state  <= AX_IDLE;
			s_bresp_o <= io_pkg::RESP_OKAY;
		end else begin
			case (wr_state)
				AX_IDLE: if (s_awvalid_i && s_wvalid_i) wr_state <= AX_ACK;
				AX_ACK: begin
					wr_state  <= AX_RESP;
					s_bresp_o <= wr_mapped ? io_pkg::RESP_OKAY : io_pkg::RESP_SLVERR;
				end
				default: if (s_bready_i) wr_state <= AX_IDLE;
			endcase
		end
	end

	// register writes, byte lane 0 only
	always_ff @(posedge clock) begin
		if (reset_i) begin
			sdc_dat_drive_o <= '0;
			sdc_dat_o       <= '0;
			sdc_clk_o       <= 1'b0;
			sdc_cmd_o       <= 1'b0;
			sdc_ena_o       <= 1'b0;
			ps2_inhibit     <= 1'b0;
			aud_duty        <= '0;
		end else if (wr_lane0) begin
			case (s_awaddr_i)
				io_pkg::REG_SDC_DIR: sdc_dat_drive_o <= s_wdata_i[3:0];
				io_pkg::REG_SDC_OUT: begin
					sdc_dat_o <= s_wdata_i[3:0];
					sdc_clk_o <= s_wdata_i[io_pkg::SDC_CLK_BIT];
					sdc_cmd_o <= s_wdata_i[io_pkg::SDC_CMD_BIT];
					sdc_ena_o <= s_wdata_i[io_pkg::SDC_ENA_BIT];
				end
				io_pkg::REG_PS2_CTRL: ps2_inhibit <= s_wdata_i[0];
				io_pkg::REG_AUD_DUTY: aud_duty    <= s_wdata_i[7:0];
				default: ;  // read only or unmapped
			endcase
		end
	end

	// read mux, unmapped reads give 0 with slverr
	always_comb begin
		rd_resp = io_pkg::RESP_OKAY;
		case (s_araddr_i)
			io_pkg::REG_SDC_DIR:  rd_data = {28'd0, sdc_dat_drive_o};
			io_pkg::REG_SDC_OUT:  rd_data = {25'd0, sdc_ena_o, sdc_cmd_o, sdc_clk_o, sdc_dat_o};
			io_pkg::REG_SDC_IN:   rd_data = {28'd0, sdc_in_q2};
			io_pkg::REG_PS2_CTRL: rd_data = {21'd0, ps2_overrun, ps2_parity_err, ps2_valid,
				7'd0, ps2_inhibit};
			io_pkg::REG_PS2_DATA: rd_data = {24'd0, ps2_byte};
			io_pkg::REG_AUD_DUTY: rd_data = {24'd0, aud_duty};
			default: begin
				rd_data = '0;
				rd_resp = io_pkg::RESP_SLVERR;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset_i) begin
			rd_state  <= AX_IDLE;
			s_rdata_o <= '0;
			s_rresp_o <= io_pkg::RESP_OKAY;
		end else begin
			case (rd_state)
				AX_IDLE: if (s_arvalid_i) rd_state <= AX_ACK;
				AX_ACK: if (rd_fire) begin
					rd_state  <= AX_RESP;
					s_rdata_o <= rd_data;  // byte sampled before the flag clear lands
					s_rresp_o <= rd_resp;
				end
				default: if (s_rready_i) rd_state <= AX_IDLE;
			endcase
		end
	end

	// two-stage synchronizer on the sd lanes
	always_ff @(posedge clock) begin
		sdc_in_q1 <= sdc_dat_in_i;
		sdc_in_q2 <= sdc_in_q1;
	end

	assign ps2_take        = rd_fire && (s_araddr_i == io_pkg::REG_PS2_DATA);
	assign ps2_clk_drive_o = ps2_inhibit;  // pad pulled low while set

	ps2_rx u_ps2_rx (
		.clock        (clock),
		.reset_i      (reset_i),
		.ps2_clk_i    (ps2_clk_in_i),
		.ps2_data_i   (ps2_data_in_i),
		.inhibit_i    (ps2_inhibit),
		.take_i       (ps2_take),
		.byte_o       (ps2_byte),
		.valid_o      (ps2_valid),
		.parity_err_o (ps2_parity_err),
		.overrun_o    (ps2_overrun)
	);

	audio_pwm u_audio_pwm (
		.clock   (clock),
		.reset_i (reset_i),
		.duty_i  (aud_duty),
		.pwm_o   (aud_pwm_o)
	);

endmodule

// ==== top_unit.sv ====
//////////////////////////////////////////////////////////////////////
// board-level wrapper: owns the tristate and open-drain pads and
// hands split in/out/enable signals to core_unit
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module top_unit (
	input  logic              clock,
	input  logic              reset_i,

	input  io_pkg::addr_t     s_awaddr_i,
	input  logic              s_awvalid_i,
	output logic              s_awready_o,
	input  io_pkg::data_t     s_wdata_i,
	input  io_pkg::strb_t     s_wstrb_i,
	input  logic              s_wvalid_i,
	output logic              s_wready_o,
	output io_pkg::resp_t     s_bresp_o,
	output logic              s_bvalid_o,
	input  logic              s_bready_i,
	input  io_pkg::addr_t     s_araddr_i,
	input  logic              s_arvalid_i,
	output logic              s_arready_o,
	output io_pkg::data_t     s_rdata_o,
	output io_pkg::resp_t     s_rresp_o,
	output logic              s_rvalid_o,
	input  logic              s_rready_i,

	inout  wire io_pkg::sdc_t sdc_dat,
	output logic              sdc_clk_o,
	output logic              sdc_cmd_o,
	output logic              sdc_ena_o,

	inout  wire               ps2_clk,
	input  logic              ps2_data_i,    // device to host only

	inout  wire               aud_mono_out
);

	io_pkg::sdc_t sdc_dat_in;
	io_pkg::sdc_t sdc_dat_out;
	io_pkg::sdc_t sdc_dat_drive;
	logic         ps2_clk_in;
	logic         ps2_clk_drive;
	logic         aud_pwm;

	// each sd lane tristated on its own enable
	for (genvar g = 0; g < 4; g++) begin : g_sdc_pad
		assign sdc_dat[g] = sdc_dat_drive[g] ? sdc_dat_out[g] : 1'bz;
	end
	assign sdc_dat_in = sdc_dat;

	assign ps2_clk    = ps2_clk_drive ? 1'b0 : 1'bz;  // open drain, inhibit
	assign ps2_clk_in = ps2_clk;

	// pwm high lets the external pull-up take the pad
	assign aud_mono_out = aud_pwm ? 1'bz : 1'b0;

	core_unit u_core_unit (
		.clock           (clock),
		.reset_i         (reset_i),
		.s_awaddr_i      (s_awaddr_i),
		.s_awvalid_i     (s_awvalid_i),
		.s_awready_o     (s_awready_o),
		.s_wdata_i       (s_wdata_i),
		.s_wstrb_i       (s_wstrb_i),
		.s_wvalid_i      (s_wvalid_i),
		.s_wready_o      (s_wready_o),
		.s_bresp_o       (s_bresp_o),
		.s_bvalid_o      (s_bvalid_o),
		.s_bready_i      (s_bready_i),
		.s_araddr_i      (s_araddr_i),
		.s_arvalid_i     (s_arvalid_i),
		.s_arready_o     (s_arready_o),
		.s_rdata_o       (s_rdata_o),
		.s_rresp_o       (s_rresp_o),
		.s_rvalid_o      (s_rvalid_o),
		.s_rready_i      (s_rready_i),
		.sdc_dat_in_i    (sdc_dat_in),
		.sdc_dat_o       (sdc_dat_out),
		.sdc_dat_drive_o (sdc_dat_drive),
		.sdc_clk_o       (sdc_clk_o),
		.sdc_cmd_o       (sdc_cmd_o),
		.sdc_ena_o       (sdc_ena_o),
		.ps2_clk_in_i    (ps2_clk_in),
		.ps2_data_in_i   (ps2_data_i),
		.ps2_clk_drive_o (ps2_clk_drive),
		.aud_pwm_o       (aud_pwm)
	);

endmodule

// ==== top_unit_checker.sv ====
//////////////////////////////////////////////////////////////////////
// concurrent checks on the axi4-lite handshake and reset state,
// bound into core_unit from this file
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module top_unit_checker (
	input logic          clock,
	input logic          reset_i,
	input logic          s_awvalid_i,
	input logic          s_wvalid_i,
	input logic          s_awready_o,
	input logic          s_wready_o,
	input logic          s_bvalid_o,
	input logic          s_bready_i,
	input io_pkg::resp_t s_bresp_o,
	input logic          s_arready_o,
	input logic          s_rvalid_o,
	input logic          s_rready_i,
	input io_pkg::data_t s_rdata_o,
	input io_pkg::resp_t s_rresp_o
);

	int unsigned fail_cnt = 0;  // failure tally

	// write response held with stable code until taken
	a_bvalid_hold: assert property (@(posedge clock) disable iff (reset_i)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
		else begin
			fail_cnt++;
			$error("write response dropped or changed before bready");
		end

	a_rvalid_hold: assert property (@(posedge clock) disable iff (reset_i)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o))
		else begin
			fail_cnt++;
			$error("read data dropped or changed before rready");
		end

	// both readies together, and only with both valids up
	a_ready_pair: assert property (@(posedge clock) disable iff (reset_i)
		$rose(s_awready_o) || $rose(s_wready_o) |->
			s_awready_o && s_wready_o && s_awvalid_i && s_wvalid_i)
		else begin
			fail_cnt++;
			$error("write ready rose without both valids or alone");
		end

	a_reset_quiet: assert property (@(posedge clock)
		reset_i |=> !s_awready_o && !s_wready_o && !s_bvalid_o && !s_arready_o && !s_rvalid_o)
		else begin
			fail_cnt++;
			$error("bus outputs not low after reset");
		end

endmodule

bind core_unit top_unit_checker u_checker (.*);

// ==== tb_top.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for top_unit: axi4-lite master, ps/2 device, pad pull-ups
// and a register model; compile with all.f, tb_top is the top
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_top;

	localparam int PS2_HALF = 8;    // clocks per ps/2 clock phase
	localparam int N_OPS    = 170;  // bus operations over all tests
	localparam int N_FRAMES = 25;
	localparam int N_DUTY   = 5;
	localparam int LIMIT    = N_OPS * 20 + N_FRAMES * 11 * 2 * (2 * PS2_HALF)
		+ N_DUTY * 3 * 300 + 2000;

	logic          clock;
	logic          reset_i;
	io_pkg::addr_t s_awaddr_i, s_araddr_i;
	io_pkg::data_t s_wdata_i, s_rdata_o;
	io_pkg::strb_t s_wstrb_i;
	io_pkg::resp_t s_bresp_o, s_rresp_o;
	logic          s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i;
	logic          s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
	logic          sdc_clk_o, sdc_cmd_o, sdc_ena_o;
	wire [3:0]     sdc_dat;
	wire           ps2_clk, ps2_data_i, aud_mono_out;

	io_pkg::sdc_t      sdc_en, sdc_val;  // testbench side of the sd lanes
	logic              dev_clk_low, dev_data_low;
	integer            seed = 32'h18eb_c035;
	io_pkg::sdc_t      m_dir;            // register model from here on
	logic [6:0]        m_out;
	logic              m_inhibit, m_valid, m_perr, m_ovr;
	io_pkg::ps2_byte_t m_byte;
	io_pkg::duty_t     m_duty;

	top_unit u_top_unit (.*);

	for (genvar g = 0; g < 4; g++) begin : g_sdc_pull
		pullup (sdc_dat[g]);
		assign sdc_dat[g] = sdc_en[g] ? sdc_val[g] : 1'bz;
	end
	pullup (ps2_clk);
	pullup (ps2_data_i);
	pullup (aud_mono_out);
	assign ps2_clk    = dev_clk_low ? 1'b0 : 1'bz;   // open-drain device
	assign ps2_data_i = dev_data_low ? 1'b0 : 1'bz;

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		repeat (LIMIT) @(posedge clock);
		$display("Timeout: tests did not finish within %0d clock cycles", LIMIT);
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

	always @(u_top_unit.u_core_unit.u_checker.fail_cnt) begin
		if (u_top_unit.u_core_unit.u_checker.fail_cnt != 0) begin
			$display("A bus assertion failed");
			$display("Testbench failed");
			$fatal(1, "assertion failure during the run");
		end
	end

	task automatic check(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		if (got !== exp) begin
			$display("Mismatch %s exp %h got %h", name, exp, got);
			$display("Testbench failed");
			$fatal(1, "check on %s failed", name);
		end
	endtask

	function automatic bit mapped(input io_pkg::addr_t a);
		return a inside {io_pkg::REG_SDC_DIR, io_pkg::REG_SDC_OUT, io_pkg::REG_SDC_IN,
			io_pkg::REG_PS2_CTRL, io_pkg::REG_PS2_DATA, io_pkg::REG_AUD_DUTY};
	endfunction

	// expected read value; sd input is dut lane, else our lane, else pull-up
	function automatic io_pkg::data_t expected(input io_pkg::addr_t a);
		case (a)
			io_pkg::REG_SDC_DIR:  return {28'd0, m_dir};
			io_pkg::REG_SDC_OUT:  return {25'd0, m_out};
			io_pkg::REG_SDC_IN:   return {28'd0, (m_dir & m_out[3:0])
				| (~m_dir & sdc_en & sdc_val) | (~m_dir & ~sdc_en)};
			io_pkg::REG_PS2_CTRL: return {21'd0, m_ovr, m_perr, m_valid, 7'd0, m_inhibit};
			io_pkg::REG_PS2_DATA: return {24'd0, m_byte};
			io_pkg::REG_AUD_DUTY: return {24'd0, m_duty};
			default:              return '0;
		endcase
	endfunction

	task automatic reg_write(input io_pkg::addr_t a, input io_pkg::data_t d,
			input io_pkg::strb_t s);
		@(negedge clock);
		s_awaddr_i  = a;
		s_wdata_i   = d;
		s_wstrb_i   = s;
		s_awvalid_i = 1'b1;
		s_wvalid_i  = 1'b1;
		@(negedge clock);
		while (!s_awready_o) @(negedge clock);
		@(negedge clock);
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		while (!s_bvalid_o) @(negedge clock);
		repeat ($unsigned($random(seed)) % 3) @(negedge clock);  // back-pressure
		check($sformatf("s_bresp_o @%h", a),
			mapped(a) ? io_pkg::RESP_OKAY : io_pkg::RESP_SLVERR, s_bresp_o);
		s_bready_i = 1'b1;
		@(negedge clock);
		s_bready_i = 1'b0;
		if (s[0]) begin
			case (a)
				io_pkg::REG_SDC_DIR:  m_dir     = d[3:0];
				io_pkg::REG_SDC_OUT:  m_out     = d[6:0];
				io_pkg::REG_PS2_CTRL: m_inhibit = d[0];
				io_pkg::REG_AUD_DUTY: m_duty    = d[7:0];
				default: ;
			endcase
		end
	endtask

	task automatic reg_read_check(input io_pkg::addr_t a);
		io_pkg::data_t exp;
		@(negedge clock);
		exp         = expected(a);  // byte and flags as seen before the clear
		s_araddr_i  = a;
		s_arvalid_i = 1'b1;
		@(negedge clock);
		while (!s_arready_o) @(negedge clock);
		@(negedge clock);
		s_arvalid_i = 1'b0;
		while (!s_rvalid_o) @(negedge clock);
		repeat ($unsigned($random(seed)) % 3) @(negedge clock);
		check($sformatf("s_rresp_o @%h", a),
			mapped(a) ? io_pkg::RESP_OKAY : io_pkg::RESP_SLVERR, s_rresp_o);
		check($sformatf("s_rdata_o @%h", a), exp, s_rdata_o);
		s_rready_i = 1'b1;
		@(negedge clock);
		s_rready_i = 1'b0;
		if (a == io_pkg::REG_PS2_DATA) begin
			m_valid = 1'b0;
			m_perr  = 1'b0;
			m_ovr   = 1'b0;
		end
	endtask

	// first n bits of a frame, lsb first
	task automatic clock_bits(input logic [10:0] frame, input int n);
		for (int i = 0; i < n; i++) begin
			dev_data_low = ~frame[i];  // data set while clock is high
			repeat (PS2_HALF) @(negedge clock);
			dev_clk_low = 1'b1;
			repeat (PS2_HALF) @(negedge clock);
			dev_clk_low = 1'b0;
		end
		dev_data_low = 1'b0;
	endtask

	// device to host frame: start, data lsb first, odd parity, stop
	task automatic send_frame(input io_pkg::ps2_byte_t b, input logic bad_par);
		clock_bits({1'b1, (~^b) ^ bad_par, b, 1'b0}, 11);
		repeat (2 * PS2_HALF) @(negedge clock);  // one bit time before reading
		if (!m_inhibit) begin
			m_ovr   = m_ovr | m_valid;
			m_perr  = m_perr | bad_par;
			m_valid = 1'b1;
			m_byte  = b;
		end
	endtask

	initial begin
		io_pkg::addr_t a;
		int            highs;
		reset_i     = 1'b1;
		s_awaddr_i  = '0;
		s_araddr_i  = '0;
		s_wdata_i   = '0;
		s_wstrb_i   = '0;
		{s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i} = '0;
		{sdc_en, sdc_val, dev_clk_low, dev_data_low} = '0;
		{m_dir, m_out, m_inhibit, m_valid, m_perr, m_ovr, m_byte, m_duty} = '0;
		repeat (5) @(negedge clock);
		reset_i = 1'b0;

		// random traffic over mapped and unmapped addresses
		for (int i = 0; i < 60; i++) begin
			if ($random(seed) & 1)
				a = 8'(($unsigned($random(seed)) % 6) * 4);
			else
				a = 8'($random(seed));
			if ($random(seed) & 1)
				reg_write(a, $random(seed), 4'($random(seed)));
			else
				reg_read_check(a);
		end

		// sd port, dut lanes out then our lanes in
		for (int k = 0; k < 6; k++) begin
			reg_write(io_pkg::REG_SDC_DIR, $random(seed), 4'h1);
			reg_write(io_pkg::REG_SDC_OUT, $random(seed), 4'h1);
			repeat (3) @(negedge clock);
			for (int g = 0; g < 4; g++)
				if (m_dir[g])
					check($sformatf("sdc_dat[%0d]", g), m_out[g], sdc_dat[g]);
			check("sdc_clk_o", m_out[io_pkg::SDC_CLK_BIT], sdc_clk_o);
			check("sdc_cmd_o", m_out[io_pkg::SDC_CMD_BIT], sdc_cmd_o);
			check("sdc_ena_o", m_out[io_pkg::SDC_ENA_BIT], sdc_ena_o);
			sdc_val = 4'($random(seed));
			sdc_en  = ~m_dir;
			repeat (3) @(negedge clock);
			reg_read_check(io_pkg::REG_SDC_IN);
			sdc_en = '0;
		end

		// ps/2 receive, about one in four frames with bad parity
		reg_write(io_pkg::REG_PS2_CTRL, 32'h0, 4'h1);
		for (int k = 0; k < 20; k++) begin
			send_frame(8'($random(seed)), ($random(seed) & 3) == 0);
			reg_read_check(io_pkg::REG_PS2_CTRL);
			reg_read_check(io_pkg::REG_PS2_DATA);
			reg_read_check(io_pkg::REG_PS2_CTRL);
		end
		send_frame(8'($random(seed)), 1'b0);  // overrun, second byte kept
		send_frame(8'($random(seed)), 1'b0);
		reg_read_check(io_pkg::REG_PS2_CTRL);
		reg_read_check(io_pkg::REG_PS2_DATA);
		reg_read_check(io_pkg::REG_PS2_CTRL);

		// inhibit mid frame drops the partial frame, then holds the clock low
		clock_bits({10'($random(seed)), 1'b0}, 5);
		reg_write(io_pkg::REG_PS2_CTRL, 32'h1, 4'h1);
		repeat (3) @(negedge clock);
		check("ps2_clk", 1'b0, ps2_clk);
		send_frame(8'($random(seed)), 1'b0);
		reg_read_check(io_pkg::REG_PS2_CTRL);
		reg_write(io_pkg::REG_PS2_CTRL, 32'h0, 4'h1);
		repeat (3) @(negedge clock);
		check("ps2_clk", 1'b1, ps2_clk);
		reg_read_check(io_pkg::REG_PS2_CTRL);
		send_frame(8'($random(seed)), 1'b0);  // clean frame after the restart
		reg_read_check(io_pkg::REG_PS2_CTRL);
		reg_read_check(io_pkg::REG_PS2_DATA);

		// audio, one full period counted after the duty settles
		for (int k = 0; k < N_DUTY; k++) begin
			reg_write(io_pkg::REG_AUD_DUTY, (k == 0) ? 32'h0 : $random(seed), 4'h1);
			repeat (512) @(negedge clock);
			highs = 0;
			repeat (256) begin
				@(negedge clock);
				if (aud_mono_out === 1'b1)
					highs++;
			end
			check("aud_mono_out high count", m_duty, highs);
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== all.f ====
io_pkg.sv
ps2_rx.sv
audio_pwm.sv
core_unit.sv
top_unit.sv
top_unit_checker.sv
tb_top.sv
